// File: verilog/fpFormatPkg.sv
`default_nettype none

// Binary32 layout and the encodings that hang off it
package fpFormatPkg;

  ////////////////////
  // Field widths
  ////////////////////
  localparam int FLen = 32;                     // Operand and result width
  localparam int NE   = 8;                      // Exponent bits
  localparam int NF   = 23;                     // Fraction bits, hidden bit not counted
  localparam int Bias = 127;                    // Exponent bias

  // All-ones exponent marks inf and NaN
  localparam logic [NE-1:0] ExpMax = NE'(2 * Bias + 1);

  // Quiet NaN returned by fmin/fmax when both inputs are NaN
  localparam logic [FLen-1:0] CanonNaN = 32'h7FC0_0000;

  ////////////////////
  // fclass mask bits
  ////////////////////
  localparam int ClassNegInf  = 0;
  localparam int ClassNegNorm = 1;
  localparam int ClassNegSub  = 2;
  localparam int ClassNegZero = 3;
  localparam int ClassPosZero = 4;
  localparam int ClassPosSub  = 5;
  localparam int ClassPosNorm = 6;
  localparam int ClassPosInf  = 7;
  localparam int ClassSNaN    = 8;
  localparam int ClassQNaN    = 9;              // Highest bit, sets the mask width

  // Exception flags, ordered NV DZ OF UF NX
  localparam int NumFlags = 5;
  localparam int FlagNV   = 4;                  // Invalid operation

endpackage

`default_nettype wire

// File: verilog/fpOpPkg.sv
`default_nettype none

// Operation encodings seen at the FPU boundary
package fpOpPkg;

  // funct5 values handled by this unit
  localparam logic [4:0] Funct5SgnJ     = 5'b00100;   // fsgnj, fsgnjn, fsgnjx
  localparam logic [4:0] Funct5MinMax   = 5'b00101;   // fmin, fmax
  localparam logic [4:0] Funct5Cmp      = 5'b10100;   // feq, flt, fle
  localparam logic [4:0] Funct5MvXClass = 5'b11100;   // fmv.x.w, fclass
  localparam logic [4:0] Funct5MvWX     = 5'b11110;   // fmv.w.x

  // Format field, single precision only
  localparam logic [1:0] FmtSingle = 2'b00;

  // funct3 within each funct5 group
  localparam logic [2:0] Fn3SgnJ  = 3'd0;
  localparam logic [2:0] Fn3SgnJN = 3'd1;
  localparam logic [2:0] Fn3SgnJX = 3'd2;
  localparam logic [2:0] Fn3Min   = 3'd0;
  localparam logic [2:0] Fn3Max   = 3'd1;
  localparam logic [2:0] Fn3Le    = 3'd0;
  localparam logic [2:0] Fn3Lt    = 3'd1;
  localparam logic [2:0] Fn3Eq    = 3'd2;
  localparam logic [2:0] Fn3Move  = 3'd0;              // Both fmv directions
  localparam logic [2:0] Fn3Class = 3'd1;

  // Bit of the compare unit select that marks fmin/fmax over eq/lt/le
  localparam int CmpSelMinMax = 2;

  // Which unit result the output carries
  typedef enum logic [2:0] {
    OpSgnJ,
    OpMinMax,
    OpCmp,
    OpClass,
    OpMove,
    OpIllegal
  } opSelT;

endpackage

`default_nettype wire

// File: verilog/opDecode.sv
`timescale 1ns/1ps
`default_nettype none

// Input stage: classify the op fields, register operands with valid
module opDecode (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [4:0]                   operation,   // funct5
  input  logic [1:0]                   format,
  input  logic [2:0]                   funct3,
  input  logic [fpFormatPkg::FLen-1:0] a,
  input  logic [fpFormatPkg::FLen-1:0] b,
  input  logic                         upValid,
  output fpOpPkg::opSelT               opSel,
  output logic [2:0]                   fn3,
  output logic [fpFormatPkg::FLen-1:0] x,
  output logic [fpFormatPkg::FLen-1:0] y,
  output logic                         validE
);

  fpOpPkg::opSelT opSelD;                             // Decoded op before the register

  // Anything not matched below stays illegal
  always_comb begin
    opSelD = fpOpPkg::OpIllegal;
    case (operation)
      fpOpPkg::Funct5SgnJ:
        if (funct3 == fpOpPkg::Fn3SgnJ || funct3 == fpOpPkg::Fn3SgnJN ||
            funct3 == fpOpPkg::Fn3SgnJX) opSelD = fpOpPkg::OpSgnJ;
      fpOpPkg::Funct5MinMax:
        if (funct3 == fpOpPkg::Fn3Min || funct3 == fpOpPkg::Fn3Max) opSelD = fpOpPkg::OpMinMax;
      fpOpPkg::Funct5Cmp:
        if (funct3 == fpOpPkg::Fn3Le || funct3 == fpOpPkg::Fn3Lt ||
            funct3 == fpOpPkg::Fn3Eq) opSelD = fpOpPkg::OpCmp;
      fpOpPkg::Funct5MvXClass: begin
        if (funct3 == fpOpPkg::Fn3Move) opSelD = fpOpPkg::OpMove;        // fmv.x.w
        else if (funct3 == fpOpPkg::Fn3Class) opSelD = fpOpPkg::OpClass;
      end
      fpOpPkg::Funct5MvWX:
        if (funct3 == fpOpPkg::Fn3Move) opSelD = fpOpPkg::OpMove;        // fmv.w.x
      default: opSelD = fpOpPkg::OpIllegal;
    endcase
    if (format != fpOpPkg::FmtSingle) opSelD = fpOpPkg::OpIllegal;     // Single only
  end

  // Payload, loads every cycle
  always_ff @(posedge clk) begin
    opSel <= opSelD;
    fn3   <= funct3;
    x     <= a;
    y     <= b;
  end

  always_ff @(posedge clk) begin
    if (reset) validE <= 1'b0;
    else       validE <= upValid;                     // No stall, one op per cycle
  end

endmodule

`default_nettype wire

// File: verilog/fpUnpack.sv
`timescale 1ns/1ps
`default_nettype none

// Split one binary32 value into fields and classify it
module fpUnpack (
  input  logic [fpFormatPkg::FLen-1:0] v,
  output logic                         sign,
  output logic [fpFormatPkg::NE-1:0]   exp,
  output logic [fpFormatPkg::NF:0]     man,        // Hidden bit on top
  output logic                         isZero,
  output logic                         isSubnorm,
  output logic                         isInf,
  output logic                         isNaN,
  output logic                         isSNaN
);

  logic [fpFormatPkg::NF-1:0] frac;
  logic                       expZero;             // Zero or subnormal
  logic                       expMax;              // Inf or NaN
  logic                       fracZero;

  assign sign = v[fpFormatPkg::FLen-1];
  assign exp  = v[fpFormatPkg::FLen-2 -: fpFormatPkg::NE];
  assign frac = v[fpFormatPkg::NF-1:0];

  assign expZero  = ~|exp;
  assign expMax   = (exp == fpFormatPkg::ExpMax);
  assign fracZero = ~|frac;

  assign man = {~expZero, frac};                   // Hidden bit only for normals

  assign isZero    = expZero & fracZero;
  assign isSubnorm = expZero & ~fracZero;
  assign isInf     = expMax & fracZero;
  assign isNaN     = expMax & ~fracZero;
  assign isSNaN    = isNaN & ~frac[fpFormatPkg::NF-1];   // Quiet bit clear

endmodule

`default_nettype wire

// File: verilog/fpCompare.sv
`timescale 1ns/1ps
`default_nettype none

// fmin/fmax and feq/flt/fle on two binary32 operands
// fn3 bit CmpSelMinMax picks min/max, low bits pick the variant
module fpCompare (
  input  logic [2:0]                   fn3,
  input  logic [fpFormatPkg::FLen-1:0] x,
  input  logic [fpFormatPkg::FLen-1:0] y,
  input  logic                         xSign,
  input  logic                         ySign,
  input  logic                         xZero,
  input  logic                         yZero,
  input  logic                         xNaN,
  input  logic                         yNaN,
  input  logic                         xSNaN,
  input  logic                         ySNaN,
  output logic [fpFormatPkg::FLen-1:0] minMaxRes,
  output logic [fpFormatPkg::FLen-1:0] cmpIntRes,
  output logic                         cmpNV
);

  logic magLt, magEq;                 // |x| vs |y|, exponent and fraction together
  logic bothZero;
  logic lt, eq;                       // Ordered, +0 == -0
  logic ltMinMax;                     // Same but -0 < +0
  logic anyNaN, anySNaN;
  logic isMinMax;
  logic cmpBit;

  ////////////////////
  // Ordering
  ////////////////////
  assign magLt    = x[fpFormatPkg::FLen-2:0] < y[fpFormatPkg::FLen-2:0];
  assign magEq    = x[fpFormatPkg::FLen-2:0] == y[fpFormatPkg::FLen-2:0];
  assign bothZero = xZero & yZero;

  always_comb begin
    case ({xSign, ySign})
      2'b00:   lt = magLt;                // Both positive
      2'b01:   lt = 1'b0;                 // x positive, y negative
      2'b10:   lt = ~bothZero;            // x negative, y positive
      default: lt = ~magLt & ~magEq;      // Both negative, bigger magnitude is smaller
    endcase
  end

  assign eq       = bothZero | (x == y);
  assign ltMinMax = lt | (xSign & ~ySign);   // Adds -0 < +0

  ////////////////////
  // NaN handling
  ////////////////////
  assign anyNaN   = xNaN | yNaN;
  assign anySNaN  = xSNaN | ySNaN;
  assign isMinMax = fn3[fpOpPkg::CmpSelMinMax];

  always_comb begin
    if (xNaN & yNaN) minMaxRes = fpFormatPkg::CanonNaN;
    else if (xNaN) minMaxRes = y;            // Other operand wins
    else if (yNaN) minMaxRes = x;
    else if ({1'b0, fn3[1:0]} == fpOpPkg::Fn3Max) minMaxRes = ltMinMax ? y : x;
    else minMaxRes = ltMinMax ? x : y;       // fmin
  end

  // Unordered results always read 0
  always_comb begin
    case (fn3)
      fpOpPkg::Fn3Eq: cmpBit = eq & ~anyNaN;
      fpOpPkg::Fn3Lt: cmpBit = lt & ~anyNaN;
      fpOpPkg::Fn3Le: cmpBit = (lt | eq) & ~anyNaN;
      default:        cmpBit = 1'b0;         // Min/max mode
    endcase
  end

  assign cmpIntRes = {{(fpFormatPkg::FLen-1){1'b0}}, cmpBit};

  // Quiet compare for feq and min/max, signaling for flt/fle
  assign cmpNV = (isMinMax | (fn3 == fpOpPkg::Fn3Eq)) ? anySNaN : anyNaN;

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

// Execute stage: unpack, run every unit in parallel, register all results
module executeStage (
  input  logic                         clk,
  input  logic                         reset,
  input  fpOpPkg::opSelT               opSel,
  input  logic [2:0]                   fn3,
  input  logic [fpFormatPkg::FLen-1:0] x,
  input  logic [fpFormatPkg::FLen-1:0] y,
  input  logic                         validE,
  output fpOpPkg::opSelT               opSelM,
  output logic [fpFormatPkg::FLen-1:0] sgnResM,
  output logic [fpFormatPkg::FLen-1:0] minMaxResM,
  output logic [fpFormatPkg::FLen-1:0] cmpIntResM,
  output logic [fpFormatPkg::FLen-1:0] classResM,
  output logic [fpFormatPkg::FLen-1:0] moveResM,
  output logic                         cmpNVM,
  output logic                         validM
);

  logic                              xSign, ySign;
  logic [fpFormatPkg::NE-1:0]        xExp;
  logic [fpFormatPkg::NF:0]          xMan;
  logic                              xZero, yZero, xSubnorm, xInf;
  logic                              xNaN, yNaN, xSNaN, ySNaN;
  logic                              xNorm;
  logic [2:0]                        cmpSel;          // fn3 with the min/max mode bit
  logic                              sgnBit;
  logic [fpFormatPkg::FLen-1:0]      sgnRes, minMaxRes, cmpIntRes, classRes;
  logic                              cmpNV;
  logic [fpFormatPkg::ClassQNaN:0]   classMask;

  ////////////////////
  // Unpack
  ////////////////////
  fpUnpack unpackX (
    .v(x), .sign(xSign), .exp(xExp), .man(xMan), .isZero(xZero), .isSubnorm(xSubnorm),
    .isInf(xInf), .isNaN(xNaN), .isSNaN(xSNaN)
  );

  // Only sign, zero and NaN classes of y are needed
  fpUnpack unpackY (
    .v(y), .sign(ySign), .exp(), .man(), .isZero(yZero), .isSubnorm(),
    .isInf(), .isNaN(yNaN), .isSNaN(ySNaN)
  );

  ////////////////////
  // Units
  ////////////////////
  always_comb begin
    cmpSel = fn3;
    cmpSel[fpOpPkg::CmpSelMinMax] = (opSel == fpOpPkg::OpMinMax);   // fmin shares fn3 0 with fle
  end

  fpCompare compare (
    .fn3(cmpSel), .x, .y, .xSign, .ySign, .xZero, .yZero, .xNaN, .yNaN, .xSNaN, .ySNaN,
    .minMaxRes, .cmpIntRes, .cmpNV
  );

  // Sign injection, magnitude always from x
  always_comb begin
    case (fn3)
      fpOpPkg::Fn3SgnJ:  sgnBit = ySign;
      fpOpPkg::Fn3SgnJN: sgnBit = ~ySign;
      fpOpPkg::Fn3SgnJX: sgnBit = xSign ^ ySign;
      default:           sgnBit = xSign;
    endcase
  end
  assign sgnRes = {sgnBit, xExp, xMan[fpFormatPkg::NF-1:0]};

  // fclass one-hot mask
  assign xNorm = xMan[fpFormatPkg::NF] & ~xInf & ~xNaN;   // Hidden bit set, not max exp
  always_comb begin
    classMask = '0;
    classMask[fpFormatPkg::ClassNegInf]  = xSign & xInf;
    classMask[fpFormatPkg::ClassNegNorm] = xSign & xNorm;
    classMask[fpFormatPkg::ClassNegSub]  = xSign & xSubnorm;
    classMask[fpFormatPkg::ClassNegZero] = xSign & xZero;
    classMask[fpFormatPkg::ClassPosZero] = ~xSign & xZero;
    classMask[fpFormatPkg::ClassPosSub]  = ~xSign & xSubnorm;
    classMask[fpFormatPkg::ClassPosNorm] = ~xSign & xNorm;
    classMask[fpFormatPkg::ClassPosInf]  = ~xSign & xInf;
    classMask[fpFormatPkg::ClassSNaN]    = xSNaN;
    classMask[fpFormatPkg::ClassQNaN]    = xNaN & ~xSNaN;
  end
  assign classRes = {{(fpFormatPkg::FLen - fpFormatPkg::ClassQNaN - 1){1'b0}}, classMask};

  // E/M register, data loads regardless of valid
  always_ff @(posedge clk) begin
    opSelM     <= opSel;
    sgnResM    <= sgnRes;
    minMaxResM <= minMaxRes;
    cmpIntResM <= cmpIntRes;
    classResM  <= classRes;
    moveResM   <= x;                                   // Both fmv forms pass a through
    cmpNVM     <= cmpNV;
  end

  always_ff @(posedge clk) begin
    if (reset) validM <= 1'b0;
    else       validM <= validE;
  end

endmodule

`default_nettype wire

// File: verilog/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

// Output stage: pick the unit result, build flags, register the output
module resultStage (
  input  logic                             clk,
  input  logic                             reset,
  input  fpOpPkg::opSelT                   opSelM,
  input  logic [fpFormatPkg::FLen-1:0]     sgnResM,
  input  logic [fpFormatPkg::FLen-1:0]     minMaxResM,
  input  logic [fpFormatPkg::FLen-1:0]     cmpIntResM,
  input  logic [fpFormatPkg::FLen-1:0]     classResM,
  input  logic [fpFormatPkg::FLen-1:0]     moveResM,
  input  logic                             cmpNVM,
  input  logic                             validM,
  output logic [fpFormatPkg::FLen-1:0]     res,
  output logic [fpFormatPkg::NumFlags-1:0] flags,
  output logic                             downValid
);

  logic [fpFormatPkg::FLen-1:0]     resNext;
  logic [fpFormatPkg::NumFlags-1:0] flagsNext;
  logic                             nv;

  always_comb begin
    nv = 1'b0;                                  // Only compare and illegal raise NV
    case (opSelM)
      fpOpPkg::OpSgnJ:   resNext = sgnResM;
      fpOpPkg::OpMinMax: begin
        resNext = minMaxResM;
        nv      = cmpNVM;
      end
      fpOpPkg::OpCmp: begin
        resNext = cmpIntResM;
        nv      = cmpNVM;
      end
      fpOpPkg::OpClass:  resNext = classResM;
      fpOpPkg::OpMove:   resNext = moveResM;
      default: begin                            // Illegal op
        resNext = '0;
        nv      = 1'b1;
      end
    endcase
  end

  always_comb begin
    flagsNext = '0;                             // DZ OF UF NX never set here
    flagsNext[fpFormatPkg::FlagNV] = nv;
  end

  // Output register
  always_ff @(posedge clk) begin
    res   <= resNext;
    flags <= flagsNext;
  end

  always_ff @(posedge clk) begin
    if (reset) downValid <= 1'b0;
    else       downValid <= validM;
  end

endmodule

`default_nettype wire

// File: verilog/fpuTop.sv
`timescale 1ns/1ps
`default_nettype none

// Three-stage single-precision FPU, non-arithmetic ops only
module fpuTop (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [4:0]                       operation,   // funct5
  input  logic [1:0]                       format,
  input  logic [2:0]                       funct3,
  input  logic [fpFormatPkg::FLen-1:0]     a,
  input  logic [fpFormatPkg::FLen-1:0]     b,
  input  logic                             upValid,
  output logic [fpFormatPkg::FLen-1:0]     res,         // FP and integer results share it
  output logic                             downValid,
  output logic [fpFormatPkg::NumFlags-1:0] flags
);

  // Decode to execute
  fpOpPkg::opSelT               opSel;
  logic [2:0]                   fn3;
  logic [fpFormatPkg::FLen-1:0] x, y;
  logic                         validE;

  // Execute to result
  fpOpPkg::opSelT               opSelM;
  logic [fpFormatPkg::FLen-1:0] sgnResM, minMaxResM, cmpIntResM, classResM, moveResM;
  logic                         cmpNVM;
  logic                         validM;

  opDecode decode (
    .clk, .reset, .operation, .format, .funct3, .a, .b, .upValid,
    .opSel, .fn3, .x, .y, .validE
  );

  executeStage execute (
    .clk, .reset, .opSel, .fn3, .x, .y, .validE,
    .opSelM, .sgnResM, .minMaxResM, .cmpIntResM, .classResM, .moveResM, .cmpNVM, .validM
  );

  resultStage result (
    .clk, .reset, .opSelM, .sgnResM, .minMaxResM, .cmpIntResM, .classResM, .moveResM,
    .cmpNVM, .validM, .res, .flags, .downValid
  );

endmodule

`default_nettype wire

// File: verif/fpuModel.svh
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

// Reference model, written from the RISC-V rules for the non-arithmetic ops

// NaN: exponent all ones, fraction nonzero
function automatic bit isNaN32(input logic [31:0] v);
  return (v[30:23] == 8'hFF) && (v[22:0] != 23'd0);
endfunction

function automatic bit isSNaN32(input logic [31:0] v);
  return isNaN32(v) && !v[22];              // Quiet bit clear
endfunction

function automatic bit bothZero(input logic [31:0] p, input logic [31:0] q);
  return (p[30:0] == 31'd0) && (q[30:0] == 31'd0);
endfunction

// p < q for non-NaN values, the two zeros equal
function automatic bit orderedLess(input logic [31:0] p, input logic [31:0] q);
  if (bothZero(p, q)) return 1'b0;
  if (p[31] != q[31]) return p[31];         // Negative below positive
  if (p[31]) return p[30:0] > q[30:0];      // Both negative
  return p[30:0] < q[30:0];
endfunction

// fclass mask, one bit per class
function automatic logic [31:0] classOf(input logic [31:0] v);
  logic [31:0] m;
  int          idx;
  if (isNaN32(v)) idx = v[22] ? fpFormatPkg::ClassQNaN : fpFormatPkg::ClassSNaN;
  else if (v[30:23] == 8'hFF) idx = v[31] ? fpFormatPkg::ClassNegInf : fpFormatPkg::ClassPosInf;
  else if (v[30:0] == 31'd0) idx = v[31] ? fpFormatPkg::ClassNegZero : fpFormatPkg::ClassPosZero;
  else if (v[30:23] == 8'h00) idx = v[31] ? fpFormatPkg::ClassNegSub : fpFormatPkg::ClassPosSub;
  else idx = v[31] ? fpFormatPkg::ClassNegNorm : fpFormatPkg::ClassPosNorm;
  m      = '0;
  m[idx] = 1'b1;
  return m;
endfunction

// Expected {flags, res} for one operation
function automatic logic [36:0] fpuExpect(input logic [4:0] op, input logic [1:0] fmt,
                                          input logic [2:0] f3, input logic [31:0] p,
                                          input logic [31:0] q);
  logic [31:0] r;
  logic [4:0]  fl;
  bit          legal;
  bit          nv;
  bit          anyNaN;
  bit          anySNaN;
  bit          minFirst;                      // p below q, -0 under +0
  r        = '0;
  fl       = '0;
  nv       = 1'b0;
  legal    = (fmt == fpOpPkg::FmtSingle);
  anyNaN   = isNaN32(p) || isNaN32(q);
  anySNaN  = isSNaN32(p) || isSNaN32(q);
  minFirst = orderedLess(p, q) || (bothZero(p, q) && p[31] && !q[31]);
  case (op)
    fpOpPkg::Funct5SgnJ:
      case (f3)
        3'd0:    r = {q[31], p[30:0]};
        3'd1:    r = {~q[31], p[30:0]};
        3'd2:    r = {p[31] ^ q[31], p[30:0]};
        default: legal = 1'b0;
      endcase
    fpOpPkg::Funct5MinMax: begin
      if (f3 > 3'd1) legal = 1'b0;
      nv = anySNaN;
      if (isNaN32(p) && isNaN32(q)) r = fpFormatPkg::CanonNaN;
      else if (isNaN32(p)) r = q;             // The number wins over a NaN
      else if (isNaN32(q)) r = p;
      else if (f3 == 3'd0) r = minFirst ? p : q;
      else r = minFirst ? q : p;
    end
    fpOpPkg::Funct5Cmp:
      case (f3)
        3'd2: begin                           // feq, quiet
          r[0] = !anyNaN && (p == q || bothZero(p, q));
          nv   = anySNaN;
        end
        3'd1: begin
          r[0] = !anyNaN && orderedLess(p, q);
          nv   = anyNaN;
        end
        3'd0: begin
          r[0] = !anyNaN && (orderedLess(p, q) || p == q || bothZero(p, q));
          nv   = anyNaN;
        end
        default: legal = 1'b0;
      endcase
    fpOpPkg::Funct5MvXClass:
      if (f3 == 3'd0) r = p;
      else if (f3 == 3'd1) r = classOf(p);
      else legal = 1'b0;
    fpOpPkg::Funct5MvWX:
      if (f3 == 3'd0) r = p;
      else legal = 1'b0;
    default: legal = 1'b0;
  endcase
  if (!legal) begin
    r  = '0;
    nv = 1'b1;
  end
  fl[fpFormatPkg::FlagNV] = nv;
  return {fl, r};
endfunction

`endif

// File: verif/fpuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpuModel.svh"

module fpuTb;

  localparam int ResetCycles = 8;
  localparam int Latency     = 3;
  localparam int NumTests    = 6;
  localparam int BurstSlots  = 60;
  localparam int DirectedOps = 24 + 32 + 42 + 18 + 7;   // Ops of tests 1 to 5
  // Drain costs about Latency + 2 cycles per test
  localparam int CycleLimit  = ResetCycles + DirectedOps + BurstSlots + Latency +
                               NumTests * (Latency + 2) + 100;

  localparam logic [31:0] PosZero = 32'h0000_0000;
  localparam logic [31:0] NegZero = 32'h8000_0000;
  localparam logic [31:0] One     = 32'h3F80_0000;
  localparam logic [31:0] Two     = 32'h4000_0000;
  localparam logic [31:0] NegOne  = 32'hBF80_0000;
  localparam logic [31:0] NegTwo  = 32'hC000_0000;
  localparam logic [31:0] QNaN    = 32'h7FC0_0000;
  localparam logic [31:0] SNaN    = 32'h7F80_0001;

  // Min/max corner pairs over zeros, one NaN, both NaN and sNaN
  localparam logic [31:0] MinMaxA [8] = '{PosZero, NegZero, QNaN, One, QNaN, SNaN, One, SNaN};
  localparam logic [31:0] MinMaxB [8] = '{NegZero, PosZero, One, QNaN, QNaN, One, SNaN, QNaN};
  localparam logic [31:0] CmpA [7] = '{One, Two, One, PosZero, QNaN, SNaN, NegTwo};
  localparam logic [31:0] CmpB [7] = '{Two, One, One, NegZero, One, One, NegOne};
  // -inf -norm -sub -0 +0 +sub +norm +inf sNaN qNaN
  localparam logic [31:0] ClassVals [10] = '{32'hFF80_0000, NegOne, 32'h8000_0001, NegZero,
                                             PosZero, 32'h0040_0000, One, 32'h7F80_0000,
                                             SNaN, QNaN};
  // {funct5, format, funct3}
  localparam logic [9:0] IllegalOps [7] = '{{5'b00000, 2'b00, 3'd0}, {5'b00100, 2'b00, 3'd3},
                                            {5'b00101, 2'b00, 3'd2}, {5'b10100, 2'b00, 3'd3},
                                            {5'b11100, 2'b00, 3'd2}, {5'b11110, 2'b00, 3'd1},
                                            {5'b00100, 2'b01, 3'd0}};
  // {funct5, funct3} of every legal op
  localparam logic [7:0] LegalOps [11] = '{{5'b00100, 3'd0}, {5'b00100, 3'd1}, {5'b00100, 3'd2},
                                           {5'b00101, 3'd0}, {5'b00101, 3'd1}, {5'b10100, 3'd0},
                                           {5'b10100, 3'd1}, {5'b10100, 3'd2}, {5'b11100, 3'd0},
                                           {5'b11100, 3'd1}, {5'b11110, 3'd0}};

  logic        clk;
  logic        reset;
  logic [4:0]  operation;
  logic [1:0]  format;
  logic [2:0]  funct3;
  logic [31:0] a;
  logic [31:0] b;
  logic        upValid;
  logic [31:0] res;
  logic        downValid;
  logic [4:0]  flags;

  logic [Latency-1:0] validHist;             // Accepted upValid, one bit per stage
  logic [36:0] expQ [$];                     // {flags, res} per op in flight
  logic [36:0] expVal;
  int          errors;
  int          checks;
  int          issued;
  int          cycles;
  int          testErrors;
  int          testsPassed;
  int          testsFailed;

  fpuTop i_dut (
    .clk, .reset, .operation, .format, .funct3, .a, .b, .upValid,
    .res, .downValid, .flags
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                  // 20 ns period
  end

  ////////////////////
  // Checkers
  ////////////////////
  // Nothing offered while in reset may come out
  always @(posedge clk) begin
    validHist <= {validHist[Latency-2:0], upValid & ~reset};
  end

  latencyCheck: assert property (@(posedge clk) disable iff (reset)
                                 downValid == validHist[Latency-1])
    else begin
      errors++;
      $display("Error: %0t ns downValid expected %b got %b", $time,
               $sampled(validHist[Latency-1]), $sampled(downValid));
    end

  resetCheck: assert property (@(posedge clk) reset |=> !downValid)
    else begin
      errors++;
      $display("Error: %0t ns downValid expected 0 got 1 after reset", $time);
    end

  // One queue entry per output beat
  always @(negedge clk) begin
    if (downValid) begin
      pendingCheck: assert (expQ.size() > 0)
        else begin
          errors++;
          $display("%0t ns: downValid high with no operation in flight", $time);
        end
      if (expQ.size() > 0) begin
        expVal = expQ.pop_front();
        checks++;
        resCheck: assert (res === expVal[31:0])
          else begin
            errors++;
            $display("Error: %0t ns res expected %h got %h", $time, expVal[31:0], res);
          end
        flagsCheck: assert (flags === expVal[36:32])
          else begin
            errors++;
            $display("Error: %0t ns flags expected %b got %b", $time, expVal[36:32], flags);
          end
      end
    end
  end

  // Timeout
  initial begin
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run did not finish within %0d cycles", CycleLimit);
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////
  // Random value with the exponent sometimes forced to zero or all ones
  function automatic logic [31:0] randFp();
    logic [31:0] v;
    v = $urandom;
    case ($urandom_range(0, 7))
      0:       v[30:23] = 8'h00;
      1:       v[30:23] = 8'hFF;
      default: ;
    endcase
    return v;
  endfunction

  task automatic issue(input logic [4:0] op, input logic [1:0] fmt, input logic [2:0] f3,
                       input logic [31:0] x, input logic [31:0] y);
    @(negedge clk);
    operation = op;
    format    = fmt;
    funct3    = f3;
    a         = x;
    b         = y;
    upValid   = 1'b1;
    expQ.push_back(fpuExpect(op, fmt, f3, x, y));
    issued++;
  endtask

  task automatic idleCycle();
    @(negedge clk);
    upValid = 1'b0;
    a       = $urandom;                      // Junk on the data lines
  endtask

  task automatic finishTest(input string name);
    idleCycle();
    while (expQ.size() != 0) @(negedge clk);
    @(negedge clk);
    if (errors == testErrors) begin
      testsPassed++;
      $display("Test %s: pass", name);
    end else begin
      testsFailed++;
      $display("Test %s: fail with %0d errors", name, errors - testErrors);
    end
    testErrors = errors;
  endtask

  ////////////////////
  // Tests
  ////////////////////
  initial begin
    int sel;
    void'($urandom(84));
    reset     = 1'b1;
    operation = '0;
    format    = '0;
    funct3    = '0;
    a         = '0;
    b         = '0;
    upValid   = 1'b1;                        // Ops offered in reset must never come out
    errors = 0;
    checks = 0;
    issued = 0;
    testErrors  = 0;
    testsPassed = 0;
    testsFailed = 0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    reset   = 1'b0;
    upValid = 1'b0;

    for (int f = 0; f < 3; f++)
      for (int i = 0; i < 8; i++)
        issue(fpOpPkg::Funct5SgnJ, fpOpPkg::FmtSingle, 3'(f), randFp(), randFp());
    finishTest("1 sign injection");

    for (int f = 0; f < 2; f++) begin
      for (int i = 0; i < 8; i++)
        issue(fpOpPkg::Funct5MinMax, fpOpPkg::FmtSingle, 3'(f), randFp(), randFp());
      for (int i = 0; i < 8; i++)
        issue(fpOpPkg::Funct5MinMax, fpOpPkg::FmtSingle, 3'(f), MinMaxA[i], MinMaxB[i]);
    end
    finishTest("2 min/max");

    for (int f = 0; f < 3; f++) begin
      for (int i = 0; i < 7; i++)
        issue(fpOpPkg::Funct5Cmp, fpOpPkg::FmtSingle, 3'(f), CmpA[i], CmpB[i]);
      for (int i = 0; i < 7; i++)
        issue(fpOpPkg::Funct5Cmp, fpOpPkg::FmtSingle, 3'(f), randFp(), randFp());
    end
    finishTest("3 compare");

    for (int i = 0; i < 10; i++)
      issue(fpOpPkg::Funct5MvXClass, fpOpPkg::FmtSingle, 3'd1, ClassVals[i], randFp());
    for (int i = 0; i < 4; i++) begin
      issue(fpOpPkg::Funct5MvXClass, fpOpPkg::FmtSingle, 3'd0, randFp(), randFp());
      issue(fpOpPkg::Funct5MvWX, fpOpPkg::FmtSingle, 3'd0, randFp(), randFp());
    end
    finishTest("4 fclass and moves");

    for (int i = 0; i < 7; i++)
      issue(IllegalOps[i][9:5], IllegalOps[i][4:3], IllegalOps[i][2:0], randFp(), randFp());
    finishTest("5 illegal ops");

    // Random burst with gaps between ops
    for (int i = 0; i < BurstSlots; i++) begin
      if ($urandom_range(0, 3) == 0) begin
        idleCycle();
      end else begin
        sel = $urandom_range(0, 10);
        issue(LegalOps[sel][7:3], fpOpPkg::FmtSingle, LegalOps[sel][2:0], randFp(), randFp());
      end
    end
    finishTest("6 pipelining");

    countCheck: assert (checks == issued)
      else begin
        errors++;
        $display("Only %0d of %0d issued operations came out", checks, issued);
      end
    $display("Summary: %0d tests passed, %0d failed, %0d results checked, %0d errors",
             testsPassed, testsFailed, checks, errors);
    if (errors == 0 && testsFailed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fpu.f
+incdir+verif
verilog/fpFormatPkg.sv
verilog/fpOpPkg.sv
verilog/opDecode.sv
verilog/fpUnpack.sv
verilog/fpCompare.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/fpuTop.sv
verif/fpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the FPU testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module fpuTb -f fpu.f -o fpuSim \
  && ./obj_dir/fpuSim > sim.log 2>&1 \
  || echo "Build or simulation returned an error"

[ -f sim.log ] || { echo "No simulation log"; exit 1; }
cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0
